// File: logic/dcache_pkg.sv
package dcache_pkg;

    // One data word of the store.
    typedef logic [31:0] word_t;

    // One enable bit per byte of word_t.
    typedef logic [$bits(word_t)/8-1:0] mask_t;

    // Word address. Only the bank and row bits are decoded.
    typedef logic [15:0] addr_t;

    // Port-A request, used by the fill port and the core write port.
    typedef struct packed {
        logic  valid;
        logic  write;              // Clear for a read.
        mask_t mask;
        addr_t addr;
        word_t data;
    } wr_req_t;

    // Read-only request on port B.
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } rd_req_t;

    // Word returned to a port.
    typedef struct packed {
        logic  valid;
        word_t data;
    } rd_rsp_t;

    // Bytes in one word.
    localparam int WORD_BYTES = $bits(mask_t);

endpackage

// File: logic/bank_ram.sv
`timescale 1ns/1ps

module bank_ram
    import dcache_pkg::*;
#(
    parameter int BANK_DEPTH = 512
) (
    input  logic    clk,
    input  wr_req_t a_req,
    input  rd_req_t b_req,
    output word_t   a_data,
    output word_t   b_data
);

    localparam int ROW_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

    word_t mem [BANK_DEPTH];

    logic [ROW_W-1:0] a_row;
    logic [ROW_W-1:0] b_row;

    // First read stage of each port, the macro output register.
    word_t a_q1;
    word_t b_q1;

    assign a_row = a_req.addr[ROW_W-1:0];
    assign b_row = b_req.addr[ROW_W-1:0];

    // Port A, masked write or read.
    always_ff @(posedge clk) begin
        if (a_req.valid) begin
            if (a_req.write) begin
                for (int i = 0; i < WORD_BYTES; i++) begin
                    if (a_req.mask[i]) begin
                        mem[a_row][i*8 +: 8] <= a_req.data[i*8 +: 8];
                    end
                end
            end else begin
                a_q1 <= mem[a_row];
            end
        end
    end

    // Port B, read only. Sees the old word on a same-edge write.
    always_ff @(posedge clk) begin
        if (b_req.valid) begin
            b_q1 <= mem[b_row];
        end
    end

    // Second stage. Matches the macro read latency.
    always_ff @(posedge clk) begin
        a_data <= a_q1;
        b_data <= b_q1;
    end

    // Router must fold the row into the bank.
    a_row_range: assert property (
        @(posedge clk) a_req.valid |-> (a_req.addr < addr_t'(BANK_DEPTH))
    ) else $error("bank_ram: port A row %0d beyond depth", a_req.addr);

    b_row_range: assert property (
        @(posedge clk) b_req.valid |-> (b_req.addr < addr_t'(BANK_DEPTH))
    ) else $error("bank_ram: port B row %0d beyond depth", b_req.addr);

endmodule

// File: logic/bank_router.sv
`timescale 1ns/1ps

module bank_router
    import dcache_pkg::*;
#(
    parameter int NUM_BANKS  = 2,
    parameter int BANK_DEPTH = 512,
    localparam int SEL_W     = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  logic             clk,
    input  logic             reset,
    input  wr_req_t          fill_req,
    input  wr_req_t          core_wr,
    input  rd_req_t          core_rd,
    output wr_req_t          bank_a [NUM_BANKS],
    output rd_req_t          bank_b [NUM_BANKS],
    output logic [SEL_W-1:0] a_sel,
    output logic [SEL_W-1:0] b_sel,
    output logic             a_rd,
    output logic             b_rd,
    output logic             core_wbusy
);

    if ((NUM_BANKS & (NUM_BANKS - 1)) != 0) begin : g_bad_banks
        $error("bank_router: NUM_BANKS must be a power of two");
    end

    // Low address bits pick the bank.
    function automatic logic [SEL_W-1:0] bank_of(input addr_t addr);
        return SEL_W'(addr % NUM_BANKS);
    endfunction

    // Next bits pick the row. Higher bits are dropped.
    function automatic addr_t row_of(input addr_t addr);
        return addr_t'((addr / NUM_BANKS) % BANK_DEPTH);
    endfunction

    logic [SEL_W-1:0] fill_bank;
    logic [SEL_W-1:0] wr_bank;
    logic [SEL_W-1:0] rd_bank;

    wr_req_t fill_row;             // Fill request with row address.
    wr_req_t wr_row;
    addr_t   rd_row;

    logic [NUM_BANKS-1:0] fill_gnt;
    logic [NUM_BANKS-1:0] core_gnt;

    always_comb begin
        fill_bank     = bank_of(fill_req.addr);
        wr_bank       = bank_of(core_wr.addr);
        rd_bank       = bank_of(core_rd.addr);
        fill_row      = fill_req;
        fill_row.addr = row_of(fill_req.addr);
        wr_row        = core_wr;
        wr_row.addr   = row_of(core_wr.addr);
        rd_row        = row_of(core_rd.addr);
    end

    // Fill always wins port A of its bank.
    assign core_wbusy = fill_req.valid && core_wr.valid && (fill_bank == wr_bank);

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            fill_gnt[b] = fill_req.valid && (fill_bank == SEL_W'(b));
            core_gnt[b] = core_wr.valid && (wr_bank == SEL_W'(b)) && !fill_gnt[b];
            if (fill_gnt[b]) begin
                bank_a[b] = fill_row;
            end else if (core_gnt[b]) begin
                bank_a[b] = wr_row;
            end else begin
                bank_a[b] = '0;
            end
            bank_b[b].valid = core_rd.valid && (rd_bank == SEL_W'(b));
            bank_b[b].addr  = rd_row;
        end
    end

    // Reads issued this cycle feed the return path.
    assign a_sel = fill_bank;
    assign a_rd  = fill_req.valid && !fill_req.write;
    assign b_sel = rd_bank;
    assign b_rd  = core_rd.valid;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_chk
        one_owner: assert property (
            @(posedge clk) disable iff (reset) !(fill_gnt[b] && core_gnt[b])
        ) else $error("bank_router: bank %0d granted twice", b);
    end

    busy_cause: assert property (
        @(posedge clk) disable iff (reset)
        core_wbusy |-> fill_req.valid && (bank_of(fill_req.addr) == bank_of(core_wr.addr))
    ) else $error("bank_router: core_wbusy without a fill in the same bank");

endmodule

// File: logic/read_return.sv
`timescale 1ns/1ps

module read_return
    import dcache_pkg::*;
#(
    parameter int NUM_BANKS = 2,
    localparam int SEL_W    = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [SEL_W-1:0] a_sel,
    input  logic [SEL_W-1:0] b_sel,
    input  logic             a_rd,
    input  logic             b_rd,
    input  word_t            a_data [NUM_BANKS],
    input  word_t            b_data [NUM_BANKS],
    output rd_rsp_t          fill_rsp,
    output rd_rsp_t          core_rsp
);

    // Index 0 is the fill port, index 1 the core port.
    logic [SEL_W-1:0] sel_q1 [2];
    logic [SEL_W-1:0] sel_q2 [2];
    logic [1:0]       rd_q1;
    logic [1:0]       rd_q2;
    logic [1:0]       rsp_valid;
    word_t            rsp_data [2];
    word_t            pick [2];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q1     <= '0;
            rd_q2     <= '0;
            rsp_valid <= '0;
            for (int p = 0; p < 2; p++) begin
                sel_q1[p] <= '0;
                sel_q2[p] <= '0;
            end
        end else begin
            rd_q1     <= {b_rd, a_rd};
            rd_q2     <= rd_q1;
            rsp_valid <= rd_q2;
            sel_q1[0] <= a_sel;
            sel_q1[1] <= b_sel;
            for (int p = 0; p < 2; p++) begin
                sel_q2[p] <= sel_q1[p];
            end
        end
    end

    // Bank words line up with the second index stage.
    assign pick[0] = a_data[sel_q2[0]];
    assign pick[1] = b_data[sel_q2[1]];

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (rd_q2[p]) begin
                rsp_data[p] <= pick[p];
            end
        end
    end

    assign fill_rsp = '{valid: rsp_valid[0], data: rsp_data[0]};
    assign core_rsp = '{valid: rsp_valid[1], data: rsp_data[1]};

    // Read sampled at one edge is visible after the second edge that follows.
    fill_latency: assert property (
        @(posedge clk) disable iff (reset) a_rd |-> ##3 fill_rsp.valid
    ) else $error("read_return: fill response missing");

    core_latency: assert property (
        @(posedge clk) disable iff (reset) b_rd |-> ##3 core_rsp.valid
    ) else $error("read_return: core response missing");

endmodule

// File: logic/dcache_banks.sv
`timescale 1ns/1ps

module dcache_banks
    import dcache_pkg::*;
#(
    parameter int NUM_BANKS  = 2,
    parameter int BANK_DEPTH = 512
) (
    input  logic    clk,
    input  logic    reset,
    input  wr_req_t fill_req,
    input  wr_req_t core_wr,
    input  rd_req_t core_rd,
    output rd_rsp_t fill_rsp,
    output rd_rsp_t core_rsp,
    output logic    core_wbusy
);

    localparam int SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    wr_req_t bank_a [NUM_BANKS];   // Port A, fill or core write.
    rd_req_t bank_b [NUM_BANKS];   // Port B, core loads.
    word_t   a_data [NUM_BANKS];
    word_t   b_data [NUM_BANKS];

    logic [SEL_W-1:0] a_sel;
    logic [SEL_W-1:0] b_sel;
    logic             a_rd;
    logic             b_rd;

    bank_router #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_router (
        .clk        (clk),
        .reset      (reset),
        .fill_req   (fill_req),
        .core_wr    (core_wr),
        .core_rd    (core_rd),
        .bank_a     (bank_a),
        .bank_b     (bank_b),
        .a_sel      (a_sel),
        .b_sel      (b_sel),
        .a_rd       (a_rd),
        .b_rd       (b_rd),
        .core_wbusy (core_wbusy)
    );

    // Words interleaved by the low address bits.
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        bank_ram #(
            .BANK_DEPTH (BANK_DEPTH)
        ) u_ram (
            .clk    (clk),
            .a_req  (bank_a[b]),
            .b_req  (bank_b[b]),
            .a_data (a_data[b]),
            .b_data (b_data[b])
        );
    end

    read_return #(
        .NUM_BANKS (NUM_BANKS)
    ) u_return (
        .clk      (clk),
        .reset    (reset),
        .a_sel    (a_sel),
        .b_sel    (b_sel),
        .a_rd     (a_rd),
        .b_rd     (b_rd),
        .a_data   (a_data),
        .b_data   (b_data),
        .fill_rsp (fill_rsp),
        .core_rsp (core_rsp)
    );

endmodule

// File: bench/dcache_banks_tb.sv
`timescale 1ns/1ps

module dcache_banks_tb
    import dcache_pkg::*;
();

    localparam int NUM_BANKS  = 2;
    localparam int BANK_DEPTH = 512;
    localparam int TOTAL      = NUM_BANKS * BANK_DEPTH;
    localparam int LAT        = 2;         // Edges from issue to response.
    localparam int TIMEOUT    = 50;
    localparam int MIX_CYCLES = 2000;

    logic    clk;
    logic    reset;
    wr_req_t fill_req;
    wr_req_t core_wr;
    rd_req_t core_rd;
    rd_rsp_t fill_rsp;
    rd_rsp_t core_rsp;
    logic    core_wbusy;

    word_t model [TOTAL];
    word_t exp_q [2][$];                   // Port 0 is fill, port 1 is core.
    int    due_q [2][$];

    integer seed;
    int     cycle;
    int     errors;
    int     tests_passed;
    int     tests_failed;
    logic   wbusy_sampled;

    dcache_banks #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_DEPTH (BANK_DEPTH)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .fill_req   (fill_req),
        .core_wr    (core_wr),
        .core_rd    (core_rd),
        .fill_rsp   (fill_rsp),
        .core_rsp   (core_rsp),
        .core_wbusy (core_wbusy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int index_of(input addr_t addr);
        return int'(addr) % TOTAL;
    endfunction

    function automatic int bank_index(input addr_t addr);
        return int'(addr) % NUM_BANKS;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input mask_t mask);
        word_t res;
        res = old;
        for (int i = 0; i < WORD_BYTES; i++) begin
            if (mask[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    function automatic addr_t rand_addr();
        return addr_t'($random(seed));
    endfunction

    function automatic mask_t rand_mask();
        return mask_t'($random(seed));
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_idle();
        fill_req = '0;
        core_wr  = '0;
        core_rd  = '0;
    endtask

    task automatic check_response(input int p, input rd_rsp_t rsp, input string name);
        word_t exp_data;
        int    due;
        if (rsp.valid) begin
            if (due_q[p].size() == 0) begin
                errors++;
                $display("%s returned a word with no read outstanding at %0t", name, $time);
            end else begin
                exp_data = exp_q[p].pop_front();
                due      = due_q[p].pop_front();
                check_value(cycle, due, {name, " arrival cycle"});
                check_value(rsp.data, exp_data, {name, " data"});
            end
        end else if (due_q[p].size() > 0 && due_q[p][0] <= cycle) begin
            errors++;
            $display("%s gave no response in cycle %0d for a read due then", name, cycle);
            void'(exp_q[p].pop_front());
            void'(due_q[p].pop_front());
        end
    endtask

    // One clock with the inputs as they stand, model updated at the same edge.
    task automatic tick();
        logic busy_exp;
        int   edge_no;
        #1;
        busy_exp = fill_req.valid && core_wr.valid
                   && (bank_index(fill_req.addr) == bank_index(core_wr.addr));
        edge_no  = cycle + 1;
        wbusy_sampled = core_wbusy;
        check_value(32'(core_wbusy), 32'(busy_exp), "core_wbusy");
        // Reads see the store before this edge's writes.
        if (fill_req.valid && !fill_req.write) begin
            exp_q[0].push_back(model[index_of(fill_req.addr)]);
            due_q[0].push_back(edge_no + LAT);
        end
        if (core_rd.valid) begin
            exp_q[1].push_back(model[index_of(core_rd.addr)]);
            due_q[1].push_back(edge_no + LAT);
        end
        if (fill_req.valid && fill_req.write) begin
            model[index_of(fill_req.addr)] = merge_bytes(model[index_of(fill_req.addr)],
                                                         fill_req.data, fill_req.mask);
        end
        if (core_wr.valid && !busy_exp) begin
            model[index_of(core_wr.addr)] = merge_bytes(model[index_of(core_wr.addr)],
                                                        core_wr.data, core_wr.mask);
        end
        @(posedge clk);
        cycle++;
        #1;
        check_response(0, fill_rsp, "fill_rsp");
        check_response(1, core_rsp, "core_rsp");
    endtask

    task automatic drain_reads();
        int waited;
        waited = 0;
        while ((due_q[0].size() > 0 || due_q[1].size() > 0) && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (due_q[0].size() > 0 || due_q[1].size() > 0) begin
            errors++;
            $display("Timed out with %0d fill and %0d core reads still outstanding",
                     due_q[0].size(), due_q[1].size());
            exp_q[0].delete();
            exp_q[1].delete();
            due_q[0].delete();
            due_q[1].delete();
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        addr_t wr_addr [64];
        int    e0;
        int    waited;
        seed          = 75;
        cycle         = 0;
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        wbusy_sampled = 1'b0;
        reset         = 1'b1;
        drive_idle();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        e0 = errors;
        check_value(32'(fill_rsp.valid), 32'd0, "fill_rsp.valid after reset");
        check_value(32'(core_rsp.valid), 32'd0, "core_rsp.valid after reset");
        check_value(32'(core_wbusy), 32'd0, "core_wbusy after reset");
        repeat (4) tick();
        finish_test("reset state", e0);

        // Every word gets a known value here.
        e0 = errors;
        for (int a = 0; a < TOTAL; a++) begin
            fill_req = '{valid: 1'b1, write: 1'b1, mask: '1, addr: addr_t'(a),
                         data: rand_word()};
            tick();
        end
        for (int a = 0; a < TOTAL; a++) begin
            fill_req = '{valid: 1'b1, write: 1'b0, mask: '0, addr: addr_t'(a), data: '0};
            tick();
        end
        drive_idle();
        drain_reads();
        finish_test("fill write and read back", e0);

        e0 = errors;
        for (int i = 0; i < 64; i++) begin
            wr_addr[i] = rand_addr();
            core_wr = '{valid: 1'b1, write: 1'b1, mask: rand_mask(), addr: wr_addr[i],
                        data: rand_word()};
            tick();
        end
        core_wr = '0;
        for (int i = 0; i < 64; i++) begin
            core_rd = '{valid: 1'b1, addr: wr_addr[i]};
            tick();
        end
        drive_idle();
        drain_reads();
        finish_test("core masked writes", e0);

        // Fill holds bank 0 for three cycles.
        e0 = errors;
        fill_req = '{valid: 1'b1, write: 1'b1, mask: '1, addr: addr_t'(8), data: rand_word()};
        core_wr  = '{valid: 1'b1, write: 1'b1, mask: '1, addr: addr_t'(20),
                     data: 32'hcafe_f00d};
        core_rd  = '{valid: 1'b1, addr: addr_t'(20)};
        tick();
        check_value(32'(wbusy_sampled), 32'd1, "core_wbusy on a bank conflict");
        core_rd       = '0;
        fill_req.addr = addr_t'(10);
        fill_req.data = rand_word();
        tick();
        fill_req.addr = addr_t'(12);
        fill_req.data = rand_word();
        tick();
        fill_req = '0;
        waited   = 0;
        do begin
            tick();
            waited++;
        end while (wbusy_sampled && waited < TIMEOUT);
        if (wbusy_sampled) begin
            errors++;
            $display("Timed out waiting for core_wbusy to drop after the fill ended");
        end
        core_wr = '0;
        core_rd = '{valid: 1'b1, addr: addr_t'(20)};
        tick();
        // Different banks, both ports write in one cycle.
        core_rd  = '0;
        fill_req = '{valid: 1'b1, write: 1'b1, mask: '1, addr: addr_t'(30), data: rand_word()};
        core_wr  = '{valid: 1'b1, write: 1'b1, mask: 4'b0101, addr: addr_t'(41),
                     data: rand_word()};
        tick();
        check_value(32'(wbusy_sampled), 32'd0, "core_wbusy with banks apart");
        core_wr  = '0;
        fill_req = '{valid: 1'b1, write: 1'b0, mask: '0, addr: addr_t'(30), data: '0};
        core_rd  = '{valid: 1'b1, addr: addr_t'(41)};
        tick();
        drive_idle();
        drain_reads();
        finish_test("fill priority stall", e0);

        e0 = errors;
        for (int i = 0; i < 32; i++) begin
            core_rd = '{valid: 1'b1, addr: addr_t'(100 + i)};
            tick();
        end
        drive_idle();
        drain_reads();
        finish_test("back to back core reads", e0);

        e0 = errors;
        wbusy_sampled = 1'b0;
        for (int i = 0; i < MIX_CYCLES; i++) begin
            fill_req = '0;
            if (1'($random(seed))) begin
                fill_req.valid = 1'b1;
                fill_req.write = 1'($random(seed));
                fill_req.mask  = rand_mask();
                fill_req.addr  = rand_addr();
                fill_req.data  = rand_word();
            end
            if (!wbusy_sampled) begin      // A stalled write is held as is.
                core_wr = '0;
                if (1'($random(seed))) begin
                    core_wr = '{valid: 1'b1, write: 1'b1, mask: rand_mask(),
                                addr: rand_addr(), data: rand_word()};
                end
            end
            core_rd = '0;
            if (1'($random(seed))) begin
                core_rd.valid = 1'b1;
                core_rd.addr  = rand_addr();
                // Sometimes aim at a word written this cycle.
                case (2'($random(seed)))
                    2'd0: begin
                        if (fill_req.valid && fill_req.write) core_rd.addr = fill_req.addr;
                    end
                    2'd1: begin
                        if (core_wr.valid) core_rd.addr = core_wr.addr;
                    end
                    default: ;
                endcase
            end
            tick();
        end
        drive_idle();
        drain_reads();
        finish_test("random mix", e0);

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
logic/dcache_pkg.sv
logic/bank_ram.sv
logic/bank_router.sv
logic/read_return.sv
logic/dcache_banks.sv
bench/dcache_banks_tb.sv

// File: Makefile
# Verilator build and run for the banked data store.

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = dcache_banks_tb
FILELIST  = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
